// File: verilog/n64a_params.svh
/*
  shared widths and constants of the N64 video input path
  colour and pixel word widths, gamma bypass code,
  gamma curve coefficients per page and gamma table read latency
*/

`ifndef N64A_PARAMS_SVH
`define N64A_PARAMS_SVH

// one colour word of the multiplexed bus
`define N64A_COLOR_W 7

// pixel word: sync nibble plus red, green and blue
`define N64A_VDATA_W (4 + 3*`N64A_COLOR_W)

// selection code that bypasses the gamma table
`define N64A_GAMMA_OFF 4

// signed curve coefficient per table page
`define N64A_GAMMA_K0 (-16)
`define N64A_GAMMA_K1 (-12)
`define N64A_GAMMA_K2 (-8)
`define N64A_GAMMA_K3 (-4)
`define N64A_GAMMA_K4 4
`define N64A_GAMMA_K5 8
`define N64A_GAMMA_K6 12
`define N64A_GAMMA_K7 16

// read latency of the gamma table in VCLK cycles
`define N64A_ROM_LAT 1

`endif

// File: verilog/n64a_video_pkg.sv
/*
  video stream types
  word phase of the multiplexed bus and the packed pixel word
*/

`default_nettype none

`include "n64a_params.svh"

package n64a_video_pkg;

  // phase of the current word within a four word pixel
  typedef enum logic [1:0] {
    PH_SYNC  = 2'd0,
    PH_RED   = 2'd1,
    PH_GREEN = 2'd2,
    PH_BLUE  = 2'd3
  } word_phase_e;

  // packed pixel, msb first
  // nsync = {nVSYNC, nCLAMP, nHSYNC, nCSYNC}
  typedef struct packed {
    logic [3:0]               nsync;
    logic [`N64A_COLOR_W-1:0] red;
    logic [`N64A_COLOR_W-1:0] green;
    logic [`N64A_COLOR_W-1:0] blue;
  } vdata_t;

endpackage

`default_nettype wire

// File: verilog/n64a_cfg_pkg.sv
/*
  configuration types
  gamma selection codes and the gamma table page index
*/

`default_nettype none

`include "n64a_params.svh"

package n64a_cfg_pkg;

  // user gamma selection, code 4 bypasses the table
  typedef enum logic [3:0] {
    GAMMA_PG0 = 4'd0,
    GAMMA_PG1 = 4'd1,
    GAMMA_PG2 = 4'd2,
    GAMMA_PG3 = 4'd3,
    GAMMA_OFF = 4'(`N64A_GAMMA_OFF),
    GAMMA_PG4 = 4'd5,
    GAMMA_PG5 = 4'd6,
    GAMMA_PG6 = 4'd7,
    GAMMA_PG7 = 4'd8
  } gamma_sel_e;

  // page index into the eight page gamma table
  typedef logic [2:0] gamma_page_t;

endpackage

`default_nettype wire

// File: verilog/n64_stream_decode.sv
/*
  stream decoder of the N64 video bus
  word phase counter, frame start detection on nVSYNC,
  configuration latch and gamma selection decode
*/

`timescale 1ns/1ps
`default_nettype none

`include "n64a_params.svh"

module n64_stream_decode (
  input  wire                         VCLK,
  input  wire                         nRST,
  input  wire                         nDSYNC_i,
  input  wire [`N64A_COLOR_W-1:0]     D_i,
  input  wire                         deblur_en_i,
  input  wire                         n64_480i_i,
  input  wire                         vmode_i,
  input  wire                         n15bit_mode_i,
  input  wire n64a_cfg_pkg::gamma_sel_e gamma_sel_i,
  output n64a_video_pkg::word_phase_e phase_o,
  output logic                        cfg_deblur_o,
  output logic                        cfg_vmode_o,
  output logic                        cfg_n15bit_o,
  output logic                        gamma_en_o,
  output n64a_cfg_pkg::gamma_page_t   gamma_page_o
);
  import n64a_video_pkg::*;
  import n64a_cfg_pkg::*;

  logic        nvsync_q;
  logic        frame_start;
  logic        sel_en;
  logic [3:0]  sel_m1;
  gamma_page_t sel_page;

  //////////////////////////////////////////////////////////////////////////
  // word phase
  //////////////////////////////////////////////////////////////////////////

  // phase of the previous bus word, saturates at blue until the next sync
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      phase_o <= PH_BLUE;
    end else if (!nDSYNC_i) begin
      phase_o <= PH_SYNC;
    end else begin
      case (phase_o)
        PH_SYNC: phase_o <= PH_RED;
        PH_RED:  phase_o <= PH_GREEN;
        default: phase_o <= PH_BLUE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // configuration latch
  //////////////////////////////////////////////////////////////////////////

  // nVSYNC falling between two sync words marks the frame start
  assign frame_start = !nDSYNC_i && nvsync_q && !D_i[3];

  // codes above the bypass code are shifted down by one page
  assign sel_en   = (gamma_sel_i != GAMMA_OFF);
  assign sel_m1   = gamma_sel_i - 4'd1;
  assign sel_page = (gamma_sel_i < GAMMA_OFF) ? gamma_sel_i[2:0] : sel_m1[2:0];

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      nvsync_q     <= 1'b0;
      cfg_deblur_o <= 1'b0;
      cfg_vmode_o  <= 1'b0;
      cfg_n15bit_o <= 1'b1;
      gamma_en_o   <= 1'b0;
      gamma_page_o <= '0;
    end else begin
      if (!nDSYNC_i)
        nvsync_q <= D_i[3];
      if (frame_start) begin
        // 480i never blanks
        cfg_deblur_o <= deblur_en_i & ~n64_480i_i;
        cfg_vmode_o  <= vmode_i;
        cfg_n15bit_o <= n15bit_mode_i;
        gamma_en_o   <= sel_en;
        gamma_page_o <= sel_page;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/n64_gamma_rom.sv
/*
  gamma table, eight pages of one curve each
  contents computed at elaboration, one registered read port
*/

`timescale 1ns/1ps
`default_nettype none

`include "n64a_params.svh"

module n64_gamma_rom (
  input  wire                       VCLK,
  input  wire                       rden_i,
  input  wire n64a_cfg_pkg::gamma_page_t page_i,
  input  wire [`N64A_COLOR_W-1:0]   addr_i,
  output logic [`N64A_COLOR_W-1:0]  data_o
);

  localparam int VMAX  = (1 << `N64A_COLOR_W) - 1;
  localparam int DEPTH = 8 << `N64A_COLOR_W;

  logic [`N64A_COLOR_W-1:0] table_q [0:DEPTH-1];

  // coefficient of one page
  function automatic int curve_k(input int p);
    case (p)
      0:       return `N64A_GAMMA_K0;
      1:       return `N64A_GAMMA_K1;
      2:       return `N64A_GAMMA_K2;
      3:       return `N64A_GAMMA_K3;
      4:       return `N64A_GAMMA_K4;
      5:       return `N64A_GAMMA_K5;
      6:       return `N64A_GAMMA_K6;
      default: return `N64A_GAMMA_K7;
    endcase
  endfunction

  // v +/- (v*(max-v)*|k|) >> 10, clamped to the colour range
  function automatic logic [`N64A_COLOR_W-1:0] curve(input int p, input int v);
    int k;
    int mag;
    int sum;
    k   = curve_k(p);
    mag = (v * (VMAX - v) * ((k < 0) ? -k : k)) >>> 10;
    sum = (k < 0) ? v - mag : v + mag;
    if (sum < 0)
      sum = 0;
    else if (sum > VMAX)
      sum = VMAX;
    return sum[`N64A_COLOR_W-1:0];
  endfunction

  initial begin
    for (int p = 0; p < 8; p++) begin
      for (int v = 0; v <= VMAX; v++)
        table_q[(p << `N64A_COLOR_W) + v] = curve(p, v);
    end
  end

  // output holds while the table is bypassed
  always_ff @(posedge VCLK) begin
    if (rden_i)
      data_o <= table_q[{page_i, addr_i}];
  end

endmodule

`default_nettype wire

// File: verilog/n64_vdemux.sv
/*
  video demux: word capture by phase, 15 bit expansion,
  deblur blanking, gamma correction through the table
  and the registered output pixel with its valid strobe
*/

`timescale 1ns/1ps
`default_nettype none

`include "n64a_params.svh"

module n64_vdemux (
  input  wire                           VCLK,
  input  wire                           nRST,
  input  wire                           nDSYNC_i,
  input  wire [`N64A_COLOR_W-1:0]       D_i,
  input  wire n64a_video_pkg::word_phase_e phase_i,
  input  wire                           cfg_deblur_i,
  input  wire                           cfg_vmode_i,
  input  wire                           cfg_n15bit_i,
  input  wire                           gamma_en_i,
  input  wire [`N64A_COLOR_W-1:0]       rom_data_i,
  output logic [`N64A_COLOR_W-1:0]      rom_addr_o,
  output n64a_video_pkg::vdata_t        vdata_o,
  output logic                          pixel_valid_o
);
  import n64a_video_pkg::*;

  // stage 0 is the assembled pixel, the last stage meets the blue result
  localparam int NSTG = `N64A_ROM_LAT + 2;

  logic [`N64A_COLOR_W-1:0] d_q;
  logic                     nsync_q;
  word_phase_e              ph_prev;
  logic                     nblank;
  logic                     csync_rise;
  logic                     px_done;

  logic [3:0]               cap_sync;
  logic [`N64A_COLOR_W-1:0] cap_r;
  logic [`N64A_COLOR_W-1:0] cap_g;

  vdata_t                   stg [0:NSTG];
  logic                     vld [0:NSTG];
  logic [`N64A_COLOR_W-1:0] gr_r;
  logic [`N64A_COLOR_W-1:0] gr_g;

  // 15 bit mode drops the two lsbs of each colour
  function automatic logic [`N64A_COLOR_W-1:0] expand(
    input logic [`N64A_COLOR_W-1:0] w,
    input logic                     n15bit
  );
    return n15bit ? w : {w[`N64A_COLOR_W-1:2], 2'b00};
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // word capture and deblur
  //////////////////////////////////////////////////////////////////////////

  // bus word aligned with the registered phase
  always_ff @(posedge VCLK) begin
    d_q <= D_i;
  end

  // pixel complete on the first blue word after green
  assign px_done    = (phase_i == PH_BLUE) && (ph_prev == PH_GREEN);
  assign csync_rise = !cap_sync[0] && d_q[0];

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      nsync_q <= 1'b1;
      ph_prev <= PH_SYNC;
      nblank  <= 1'b1;
    end else begin
      nsync_q <= nDSYNC_i;
      ph_prev <= phase_i;
      if (!nsync_q) begin
        if (!cfg_deblur_i)
          nblank <= 1'b1;
        else if (csync_rise)
          // resync the blank pattern to the line start
          nblank <= cfg_vmode_i;
        else
          nblank <= ~nblank;
      end
    end
  end

  always_ff @(posedge VCLK) begin
    if (!nsync_q) begin
      cap_sync <= d_q[3:0];
    end else begin
      case (phase_i)
        PH_RED:   cap_r <= expand(d_q, cfg_n15bit_i);
        PH_GREEN: cap_g <= expand(d_q, cfg_n15bit_i);
        default:  ;
      endcase
    end
  end

  // stage 0, blanked pixels keep the previous colours
  always_ff @(posedge VCLK) begin
    if (px_done) begin
      stg[0].nsync <= cap_sync;
      if (nblank) begin
        stg[0].red   <= cap_r;
        stg[0].green <= cap_g;
        stg[0].blue  <= expand(d_q, cfg_n15bit_i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // gamma and delay line
  //////////////////////////////////////////////////////////////////////////

  // red, green and blue go to the table on three consecutive cycles
  always_comb begin
    if (vld[1])
      rom_addr_o = stg[1].green;
    else if (vld[2])
      rom_addr_o = stg[2].blue;
    else
      rom_addr_o = stg[0].red;
  end

  always_ff @(posedge VCLK) begin
    for (int i = 1; i <= NSTG; i++)
      stg[i] <= stg[i-1];
    if (vld[`N64A_ROM_LAT])
      gr_r <= rom_data_i;
    if (vld[`N64A_ROM_LAT+1])
      gr_g <= rom_data_i;
  end

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      for (int i = 0; i <= NSTG; i++)
        vld[i] <= 1'b0;
    end else begin
      vld[0] <= px_done;
      for (int i = 1; i <= NSTG; i++)
        vld[i] <= vld[i-1];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // result stage
  //////////////////////////////////////////////////////////////////////////

  // blue comes straight from the table in the last stage
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      vdata_o       <= '0;
      pixel_valid_o <= 1'b0;
    end else begin
      pixel_valid_o <= vld[NSTG];
      if (vld[NSTG]) begin
        if (gamma_en_i)
          vdata_o <= {stg[NSTG].nsync, gr_r, gr_g, rom_data_i};
        else
          vdata_o <= stg[NSTG];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/n64a_video_top.sv
/*
  top level of the video input path
  stream decoder, demux and gamma table
*/

`timescale 1ns/1ps
`default_nettype none

`include "n64a_params.svh"

module n64a_video_top (
  input  wire                           VCLK,
  input  wire                           nRST,
  input  wire                           nDSYNC_i,
  input  wire [`N64A_COLOR_W-1:0]       D_i,
  input  wire                           deblur_en_i,
  input  wire                           n64_480i_i,
  input  wire                           vmode_i,
  input  wire                           n15bit_mode_i,
  input  wire n64a_cfg_pkg::gamma_sel_e gamma_sel_i,
  output n64a_video_pkg::vdata_t        vdata_o,
  output logic                          pixel_valid_o
);
  import n64a_video_pkg::*;
  import n64a_cfg_pkg::*;

  word_phase_e              phase;
  logic                     cfg_deblur;
  logic                     cfg_vmode;
  logic                     cfg_n15bit;
  logic                     gamma_en;
  gamma_page_t              gamma_page;
  logic [`N64A_COLOR_W-1:0] rom_addr;
  logic [`N64A_COLOR_W-1:0] rom_data;

  // decode stage
  n64_stream_decode n64_stream_decode_i (
    .VCLK          (VCLK),
    .nRST          (nRST),
    .nDSYNC_i      (nDSYNC_i),
    .D_i           (D_i),
    .deblur_en_i   (deblur_en_i),
    .n64_480i_i    (n64_480i_i),
    .vmode_i       (vmode_i),
    .n15bit_mode_i (n15bit_mode_i),
    .gamma_sel_i   (gamma_sel_i),
    .phase_o       (phase),
    .cfg_deblur_o  (cfg_deblur),
    .cfg_vmode_o   (cfg_vmode),
    .cfg_n15bit_o  (cfg_n15bit),
    .gamma_en_o    (gamma_en),
    .gamma_page_o  (gamma_page)
  );

  // execute and result stage
  n64_vdemux n64_vdemux_i (
    .VCLK          (VCLK),
    .nRST          (nRST),
    .nDSYNC_i      (nDSYNC_i),
    .D_i           (D_i),
    .phase_i       (phase),
    .cfg_deblur_i  (cfg_deblur),
    .cfg_vmode_i   (cfg_vmode),
    .cfg_n15bit_i  (cfg_n15bit),
    .gamma_en_i    (gamma_en),
    .rom_data_i    (rom_data),
    .rom_addr_o    (rom_addr),
    .vdata_o       (vdata_o),
    .pixel_valid_o (pixel_valid_o)
  );

  n64_gamma_rom n64_gamma_rom_i (
    .VCLK   (VCLK),
    .rden_i (gamma_en),
    .page_i (gamma_page),
    .addr_i (rom_addr),
    .data_o (rom_data)
  );

endmodule

`default_nettype wire

// File: bench/n64a_video_checker.sv
/*
  concurrent assertions on the outputs of the video top level
  strobe width, reset values and pipeline depth, attached with bind
*/

`timescale 1ns/1ps
`default_nettype none

module n64a_video_checker (
  input wire                         VCLK,
  input wire                         nRST,
  input wire                         nDSYNC_i,
  input wire n64a_video_pkg::vdata_t vdata_o,
  input wire                         pixel_valid_o
);

  // failed assertions, read by the testbench at the end of the run
  int fail_cnt = 0;

  // one pulse per pixel, never two in a row
  assert property (@(posedge VCLK) disable iff (!nRST) pixel_valid_o |=> !pixel_valid_o)
    else begin
      fail_cnt++;
      $error("pixel_valid_o high in two adjacent cycles");
    end

  // outputs cleared by reset
  assert property (@(posedge VCLK) $rose(nRST) |-> (vdata_o == '0) && !pixel_valid_o)
    else begin
      fail_cnt++;
      $error("vdata_o or pixel_valid_o not zero after reset");
    end

  // sync, red, green, blue, then the pixel six cycles after the blue word
  assert property (@(posedge VCLK) disable iff (!nRST)
    (!nDSYNC_i ##1 nDSYNC_i ##1 nDSYNC_i ##1 nDSYNC_i) |-> ##6 $rose(pixel_valid_o))
    else begin
      fail_cnt++;
      $error("pixel_valid_o did not rise six cycles after the blue word");
    end

endmodule

bind n64a_video_top n64a_video_checker n64a_video_checker_i (
  .VCLK          (VCLK),
  .nRST          (nRST),
  .nDSYNC_i      (nDSYNC_i),
  .vdata_o       (vdata_o),
  .pixel_valid_o (pixel_valid_o)
);

`default_nettype wire

// File: bench/n64a_video_tb.sv
/*
  testbench of the video input path
  clock, reset, watchdog, reference model of the pixel stream,
  directed tests for bypass, 15 bit, gamma pages, config latch and deblur
*/

`timescale 1ns/1ps
`default_nettype none

`include "n64a_params.svh"

module n64a_video_tb;
  import n64a_video_pkg::*;
  import n64a_cfg_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int CMAX       = (1 << `N64A_COLOR_W) - 1;
  localparam int RAMP_PX    = 43;
  localparam int DEBLUR_PX  = 13;
  // warm-up, bypass, 15 bit, gamma pages, config latch, deblur
  localparam int N_PIXELS   = 1 + 12 + 8 + 8 * (RAMP_PX + 4) + 16 + 3 * DEBLUR_PX;

  logic                     VCLK;
  logic                     nRST;
  logic                     nDSYNC_i;
  logic [`N64A_COLOR_W-1:0] D_i;
  logic                     deblur_en_i;
  logic                     n64_480i_i;
  logic                     vmode_i;
  logic                     n15bit_mode_i;
  gamma_sel_e               gamma_sel_i;
  vdata_t                   vdata_o;
  logic                     pixel_valid_o;

  // configuration the next bus word carries
  logic       in_deblur;
  logic       in_480i;
  logic       in_vmode;
  logic       in_n15;
  gamma_sel_e in_gsel;

  // reference model state
  logic                     m_deblur;
  logic                     m_vmode;
  logic                     m_n15;
  logic                     m_gen;
  int                       m_page;
  logic                     prev_vs;
  logic                     prev_csync;
  logic                     nblank;
  logic [`N64A_COLOR_W-1:0] held_r;
  logic [`N64A_COLOR_W-1:0] held_g;
  logic [`N64A_COLOR_W-1:0] held_b;

  int coef [0:7] = '{`N64A_GAMMA_K0, `N64A_GAMMA_K1, `N64A_GAMMA_K2, `N64A_GAMMA_K3,
                     `N64A_GAMMA_K4, `N64A_GAMMA_K5, `N64A_GAMMA_K6, `N64A_GAMMA_K7};

  vdata_t exp_q [$];
  vdata_t exp_px;
  int     sent_count    = 0;
  int     rcv_count     = 0;
  int     mismatch_errs = 0;
  int     other_errs    = 0;
  int     assert_errs;

  n64a_video_top n64a_video_top_i (
    .VCLK          (VCLK),
    .nRST          (nRST),
    .nDSYNC_i      (nDSYNC_i),
    .D_i           (D_i),
    .deblur_en_i   (deblur_en_i),
    .n64_480i_i    (n64_480i_i),
    .vmode_i       (vmode_i),
    .n15bit_mode_i (n15bit_mode_i),
    .gamma_sel_i   (gamma_sel_i),
    .vdata_o       (vdata_o),
    .pixel_valid_o (pixel_valid_o)
  );

  initial begin
    VCLK = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK = ~VCLK;
  end

  // bound on the whole run
  initial begin
    #(CLK_PERIOD * (RST_CYCLES + 64 * N_PIXELS));
    $display("timeout: the pixel stream did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // v bent by v*(max-v)*|k|/1024 toward the sign of k, kept in range
  function automatic logic [`N64A_COLOR_W-1:0] gamma_ref(input int page, input int v);
    int k;
    int bend;
    int y;
    k    = coef[page];
    bend = (v * (CMAX - v) * ((k < 0) ? -k : k)) >> 10;
    y    = (k < 0) ? (v - bend) : (v + bend);
    if (y < 0)
      y = 0;
    if (y > CMAX)
      y = CMAX;
    return y[`N64A_COLOR_W-1:0];
  endfunction

  // 15 bit words keep the five upper bits
  function automatic logic [`N64A_COLOR_W-1:0] widen(input logic [`N64A_COLOR_W-1:0] w,
                                                      input logic n15);
    return n15 ? w : ((w >> 2) << 2);
  endfunction

  function automatic logic [`N64A_COLOR_W-1:0] rand_color();
    return $urandom & CMAX;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // one bus word together with the current configuration inputs
  task automatic drive_word(input logic nds, input logic [`N64A_COLOR_W-1:0] d);
    @(posedge VCLK);
    nDSYNC_i      <= nds;
    D_i           <= d;
    deblur_en_i   <= in_deblur;
    n64_480i_i    <= in_480i;
    vmode_i       <= in_vmode;
    n15bit_mode_i <= in_n15;
    gamma_sel_i   <= in_gsel;
  endtask

  // idle words let the pipeline drain before a configuration change
  task automatic idle(input int n);
    repeat (n) drive_word(1'b1, '0);
  endtask

  // sends one pixel and queues the pixel the rules predict for it
  task automatic send_pixel(input logic [3:0] nsync, input logic [`N64A_COLOR_W-1:0] r,
                            input logic [`N64A_COLOR_W-1:0] g,
                            input logic [`N64A_COLOR_W-1:0] b);
    vdata_t px;
    // falling nVSYNC between two sync words takes up the configuration
    if (!nsync[3] && prev_vs) begin
      m_deblur = in_deblur & ~in_480i;
      m_vmode  = in_vmode;
      m_n15    = in_n15;
      m_gen    = (in_gsel != GAMMA_OFF);
      m_page   = (int'(in_gsel) < `N64A_GAMMA_OFF) ? int'(in_gsel) : int'(in_gsel) - 1;
    end
    prev_vs = nsync[3];
    if (!m_deblur)
      nblank = 1'b1;
    else if (!prev_csync && nsync[0])
      nblank = m_vmode;
    else
      nblank = ~nblank;
    prev_csync = nsync[0];
    if (nblank) begin
      held_r = widen(r, m_n15);
      held_g = widen(g, m_n15);
      held_b = widen(b, m_n15);
    end
    px.nsync = nsync;
    px.red   = m_gen ? gamma_ref(m_page, held_r) : held_r;
    px.green = m_gen ? gamma_ref(m_page, held_g) : held_g;
    px.blue  = m_gen ? gamma_ref(m_page, held_b) : held_b;
    exp_q.push_back(px);
    sent_count++;
    drive_word(1'b0, {3'b000, nsync});
    drive_word(1'b1, r);
    drive_word(1'b1, g);
    drive_word(1'b1, b);
  endtask

  // random pixels, optionally opening a new frame
  task automatic send_random(input int n, input bit new_frame);
    logic [3:0] ns;
    if (new_frame)
      idle(8);
    for (int i = 0; i < n; i++) begin
      ns = {1'b1, 3'($urandom)};
      if (new_frame && i == 0)
        ns[3] = 1'b0;
      send_pixel(ns, rand_color(), rand_color(), rand_color());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_bypass();
    in_gsel = GAMMA_OFF;
    in_n15  = 1'b1;
    send_random(12, 1'b1);
  endtask

  task automatic test_15bit();
    in_n15 = 1'b0;
    send_random(8, 1'b1);
    in_n15 = 1'b1;
  endtask

  // a ramp over all input values, then random words, on each page
  task automatic test_gamma_pages();
    logic [3:0] ns;
    for (int c = 0; c < 9; c++) begin
      if (c == `N64A_GAMMA_OFF)
        continue;
      in_gsel = gamma_sel_e'(c);
      idle(8);
      for (int i = 0; i < RAMP_PX; i++) begin
        ns = (i == 0) ? 4'b0111 : 4'b1111;
        send_pixel(ns, 7'(3 * i), 7'(3 * i + 1), 7'(3 * i + 2));
      end
      send_random(4, 1'b0);
    end
  endtask

  // inputs change inside a frame, the DUT follows at the next frame
  task automatic test_cfg_latch();
    in_gsel = GAMMA_OFF;
    in_n15  = 1'b1;
    send_random(4, 1'b1);
    in_gsel = GAMMA_PG6;
    in_n15  = 1'b0;
    send_random(6, 1'b0);
    send_random(6, 1'b1);
  endtask

  // steady nCSYNC toggles the blanking, one low word then a rise resyncs it
  // the rise lands where a plain toggle would give the opposite of vmode
  task automatic deblur_frame(input logic vmode, input logic i480);
    logic [3:0] ns;
    in_gsel   = GAMMA_OFF;
    in_n15    = 1'b1;
    in_deblur = 1'b1;
    in_480i   = i480;
    in_vmode  = vmode;
    idle(8);
    for (int i = 0; i < DEBLUR_PX; i++) begin
      ns = {(i != 0), 2'b11, (i != 6 + vmode)};
      send_pixel(ns, rand_color(), rand_color(), rand_color());
    end
  endtask

  task automatic test_deblur();
    deblur_frame(1'b0, 1'b0);
    deblur_frame(1'b1, 1'b0);
    deblur_frame(1'b0, 1'b1);
    in_deblur = 1'b0;
    in_480i   = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_pixel(input vdata_t got, input vdata_t exp, input int idx);
    if (got !== exp) begin
      mismatch_errs++;
      $display("MISMATCH vdata_o pixel %0d: got %h expected %h", idx, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp);
    if (got != exp) begin
      mismatch_errs++;
      $display("MISMATCH pixel_valid_o count: got %h expected %h", got, exp);
    end
  endtask

  // outputs are sampled mid cycle, away from the driving edge
  always @(negedge VCLK) begin
    if (nRST && pixel_valid_o) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("pixel strobe seen with no pixel left to expect");
      end else begin
        exp_px = exp_q.pop_front();
        compare_pixel(vdata_o, exp_px, rcv_count);
      end
      rcv_count++;
    end
  end

  initial begin
    int seed;
    seed          = $urandom(5);
    nRST          = 1'b0;
    nDSYNC_i      = 1'b1;
    D_i           = '0;
    deblur_en_i   = 1'b0;
    n64_480i_i    = 1'b0;
    vmode_i       = 1'b0;
    n15bit_mode_i = 1'b1;
    gamma_sel_i   = GAMMA_OFF;
    in_deblur     = 1'b0;
    in_480i       = 1'b0;
    in_vmode      = 1'b0;
    in_n15        = 1'b1;
    in_gsel       = GAMMA_OFF;
    // reset values of the configuration latch
    m_deblur      = 1'b0;
    m_vmode       = 1'b0;
    m_n15         = 1'b1;
    m_gen         = 1'b0;
    m_page        = 0;
    prev_vs       = 1'b0;
    prev_csync    = 1'b1;
    nblank        = 1'b1;
    held_r        = '0;
    held_g        = '0;
    held_b        = '0;
    repeat (RST_CYCLES) @(posedge VCLK);
    nRST <= 1'b1;
    idle(4);
    // nVSYNC high once so the first frame start qualifies
    send_pixel(4'b1111, rand_color(), rand_color(), rand_color());
    test_bypass();
    test_15bit();
    test_gamma_pages();
    test_cfg_latch();
    test_deblur();
    idle(2);
    for (int i = 0; i < 64; i++) begin
      if (rcv_count == sent_count)
        break;
      @(posedge VCLK);
    end
    // extra strobes would show up here
    repeat (8) @(posedge VCLK);
    compare_count(rcv_count, sent_count);
    assert_errs = n64a_video_top_i.n64a_video_checker_i.fail_cnt;
    $display("errors: %0d mismatches, %0d other, %0d assertions",
             mismatch_errs, other_errs, assert_errs);
    if (mismatch_errs == 0 && other_errs == 0 && assert_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/n64a_video_pkg.sv
verilog/n64a_cfg_pkg.sv
verilog/n64_stream_decode.sv
verilog/n64_gamma_rom.sv
verilog/n64_vdemux.sv
verilog/n64a_video_top.sv
bench/n64a_video_checker.sv
bench/n64a_video_tb.sv
